//--- hdl/usb_out_defs.svh
`ifndef USB_OUT_DEFS_SVH
`define USB_OUT_DEFS_SVH

//////////////////////////////
// Endpoint and packet sizing
//////////////////////////////

// OUT endpoints implemented in hardware
`define USB_NUM_OUT_EPS 4

// Largest packet the endpoints accept
`define USB_MAX_PKT_BYTES 32

// Byte offset width, log2 of the packet size
`define USB_PUT_ADDR_W 5

//////////////////////////////
// Handshake timing
//////////////////////////////

// 17 bit times at 4 clocks per bit on the 48 MHz clock
`define USB_ACK_TIMEOUT_CNT 68

// Wide enough to hold the timeout count
`define USB_TIMEOUT_W 7

`endif

//--- hdl/usb_out_pkg.sv
`include "usb_out_defs.svh"

package usb_out_pkg;

  // PID codes, low two bits give the PID type
  typedef enum logic [3:0] {
    pid_out   = 4'b0001,
    pid_in    = 4'b1001,
    pid_setup = 4'b1101,
    pid_data0 = 4'b0011,
    pid_data1 = 4'b1011,
    pid_ack   = 4'b0010,
    pid_nak   = 4'b1010,
    pid_stall = 4'b1110
  } usb_pid_e;

  typedef logic [6:0]                      dev_addr_t;
  typedef logic [3:0]                      endp_t;
  typedef logic [$clog2(`USB_NUM_OUT_EPS)-1:0] ep_idx_t;
  typedef logic [`USB_NUM_OUT_EPS-1:0]     ep_mask_t;
  typedef logic [`USB_PUT_ADDR_W-1:0]      put_addr_t;

  // Receive side strobes and token fields
  typedef struct packed {
    logic      pkt_start;
    logic      pkt_end;
    logic      pkt_valid;
    logic [3:0] pid;
    dev_addr_t addr;
    endp_t     endp;
  } rx_pkt_t;

  typedef struct packed {
    logic       put;
    logic [7:0] data;
  } rx_byte_t;

  // Per endpoint configuration from the endpoint side
  typedef struct packed {
    ep_mask_t enabled;
    ep_mask_t control;
    ep_mask_t full;
    ep_mask_t stall;
  } ep_cfg_t;

  // Decoded packet events for one cycle
  typedef struct packed {
    logic  out_tok;
    logic  setup_tok;
    logic  data_pkt;
    logic  bad_pkt;
    logic  ep_active;
    logic  ep_control;
    logic  bad_toggle;
    endp_t ep_num;
  } tok_evt_t;

  typedef enum logic [1:0] {
    tog_none,
    tog_clear,
    tog_flip
  } toggle_op_e;

  typedef struct packed {
    toggle_op_e op;
    ep_idx_t    idx;
  } toggle_cmd_t;

  // Byte stream towards the endpoint
  typedef struct packed {
    logic       put;
    put_addr_t  addr;
    logic [7:0] data;
  } ep_put_t;

  typedef enum logic [2:0] {
    st_idle,
    st_got_token,
    st_data_wait,
    st_data_end
  } xact_state_e;

endpackage

//--- hdl/usb_token_decode.sv
`timescale 1ns/1ps
`include "usb_out_defs.svh"

module usb_token_decode (
  input  usb_out_pkg::dev_addr_t dev_addr_i,
  input  usb_out_pkg::rx_pkt_t   rx_pkt_i,
  input  usb_out_pkg::ep_cfg_t   ep_cfg_i,
  input  usb_out_pkg::ep_mask_t  toggle_i,
  output usb_out_pkg::tok_evt_t  evt_o
);

  localparam int unsigned idx_w = $bits(usb_out_pkg::ep_idx_t);

  usb_out_pkg::usb_pid_e pid;
  usb_out_pkg::ep_idx_t  ep_idx;
  logic                  tok_match;
  logic                  is_data;
  logic                  ep_in_hw;

  assign pid = usb_out_pkg::usb_pid_e'(rx_pkt_i.pid);

  // Token type is 01 in the low PID bits
  assign tok_match = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid &&
                     (rx_pkt_i.pid[1:0] == 2'b01) && (rx_pkt_i.addr == dev_addr_i);

  assign is_data = (pid == usb_out_pkg::pid_data0) || (pid == usb_out_pkg::pid_data1);

  // Endpoints beyond the hardware count map to 0
  assign ep_in_hw = int'(rx_pkt_i.endp) < `USB_NUM_OUT_EPS;
  assign ep_idx   = ep_in_hw ? rx_pkt_i.endp[idx_w-1:0] : '0;

  always_comb begin
    evt_o.out_tok   = tok_match && (pid == usb_out_pkg::pid_out);
    evt_o.setup_tok = tok_match && (pid == usb_out_pkg::pid_setup);
    evt_o.data_pkt  = rx_pkt_i.pkt_end && rx_pkt_i.pkt_valid && is_data;
    // Corrupt packet, or a valid one that is neither data nor our OUT or SETUP token
    evt_o.bad_pkt   = rx_pkt_i.pkt_end && !evt_o.out_tok && !evt_o.setup_tok &&
                      (!rx_pkt_i.pkt_valid || !is_data);

    evt_o.ep_num     = ep_in_hw ? rx_pkt_i.endp : '0;
    evt_o.ep_active  = ep_in_hw && ep_cfg_i.enabled[ep_idx];
    evt_o.ep_control = ep_cfg_i.control[ep_idx];

    // PID bit 3 selects DATA1 over DATA0
    evt_o.bad_toggle = evt_o.data_pkt && evt_o.ep_active &&
                       (rx_pkt_i.pid[3] != toggle_i[ep_idx]);

    // Token, data and bad packet classes exclude each other
    evt_class_onehot: assert ($onehot0({evt_o.out_tok, evt_o.setup_tok,
                                        evt_o.data_pkt, evt_o.bad_pkt}));
  end

endmodule

//--- hdl/usb_out_xact_fsm.sv
`timescale 1ns/1ps
`include "usb_out_defs.svh"

module usb_out_xact_fsm (
  input  logic                     clk_48mhz_i,
  input  logic                     rst_ni,
  input  logic                     link_reset_i,
  input  usb_out_pkg::tok_evt_t    evt_i,
  input  logic                     rx_pkt_start_i,
  input  usb_out_pkg::ep_cfg_t     ep_cfg_i,
  input  logic                     nak_pending_i,
  output logic                     tx_pkt_start_o,
  output usb_out_pkg::usb_pid_e    tx_pid_o,
  output usb_out_pkg::endp_t       out_ep_current_o,
  output logic                     out_ep_newpkt_o,
  output logic                     out_ep_acked_o,
  output logic                     out_ep_rollback_o,
  output usb_out_pkg::ep_mask_t    out_ep_setup_o,
  output logic                     data_phase_o,
  output logic                     xact_start_o,
  output usb_out_pkg::toggle_cmd_t toggle_cmd_o
);

  localparam int unsigned idx_w = $bits(usb_out_pkg::ep_idx_t);

  typedef logic [`USB_TIMEOUT_W-1:0] timeout_t;

  localparam timeout_t timeout_init = timeout_t'(`USB_ACK_TIMEOUT_CNT);
  localparam usb_out_pkg::usb_pid_e pid_idle = usb_out_pkg::usb_pid_e'(4'h0);

  usb_out_pkg::xact_state_e state_q, state_d;
  usb_out_pkg::usb_pid_e    tx_pid_d;
  usb_out_pkg::ep_idx_t     idx_q, idx_d;
  timeout_t                 timeout_q, timeout_d;
  logic                     setup_q;
  logic                     tx_start_d, acked_d, rollback_d;
  logic                     ep_full;

  // Token endpoint in this cycle, latched endpoint afterwards
  assign idx_d   = evt_i.ep_num[idx_w-1:0];
  assign idx_q   = out_ep_current_o[idx_w-1:0];
  assign ep_full = ep_cfg_i.full[idx_q] || nak_pending_i;

  assign data_phase_o = (state_q == usb_out_pkg::st_data_wait);

  //////////////////////////////
  // Next state and reply
  //////////////////////////////
  always_comb begin
    state_d      = state_q;
    xact_start_o = 1'b0;
    tx_start_d   = 1'b0;
    tx_pid_d     = pid_idle;
    acked_d      = 1'b0;
    rollback_d   = 1'b0;
    timeout_d    = timeout_init;

    unique case (state_q)
      usb_out_pkg::st_idle: begin
        // SETUP only counts on a control endpoint
        if (evt_i.ep_active &&
            (evt_i.out_tok || (evt_i.setup_tok && evt_i.ep_control))) begin
          state_d      = usb_out_pkg::st_got_token;
          xact_start_o = 1'b1;
        end
      end

      usb_out_pkg::st_got_token: begin
        timeout_d = timeout_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = usb_out_pkg::st_data_wait;
        end else if (timeout_q == '0) begin
          // Host data never came, drop silently
          state_d = usb_out_pkg::st_idle;
        end
      end

      usb_out_pkg::st_data_wait: begin
        if (evt_i.bad_toggle && !ep_cfg_i.stall[idx_q]) begin
          // Repeat of data already taken, host lost our ACK
          state_d    = usb_out_pkg::st_idle;
          tx_start_d = 1'b1;
          tx_pid_d   = usb_out_pkg::pid_ack;
          rollback_d = 1'b1;
        end else if (evt_i.bad_pkt || evt_i.out_tok || evt_i.setup_tok) begin
          // Anything but data ends the transaction
          state_d    = usb_out_pkg::st_idle;
          rollback_d = 1'b1;
        end else if (evt_i.data_pkt) begin
          state_d = usb_out_pkg::st_data_end;
        end
      end

      usb_out_pkg::st_data_end: begin
        state_d = usb_out_pkg::st_idle;
        if (setup_q) begin
          // SETUP is never NAKed, failed ones get no reply
          if (ep_full) begin
            rollback_d = 1'b1;
          end else begin
            tx_start_d = 1'b1;
            tx_pid_d   = usb_out_pkg::pid_ack;
            acked_d    = 1'b1;
          end
        end else if (ep_cfg_i.stall[idx_q]) begin
          tx_start_d = 1'b1;
          tx_pid_d   = usb_out_pkg::pid_stall;
        end else if (ep_full) begin
          tx_start_d = 1'b1;
          tx_pid_d   = usb_out_pkg::pid_nak;
          rollback_d = 1'b1;
        end else begin
          tx_start_d = 1'b1;
          tx_pid_d   = usb_out_pkg::pid_ack;
          acked_d    = 1'b1;
        end
      end

      default: state_d = usb_out_pkg::st_idle;
    endcase
  end

  // Toggle update, SETUP clear wins over accept flip
  always_comb begin
    toggle_cmd_o.op  = usb_out_pkg::tog_none;
    toggle_cmd_o.idx = idx_q;
    if (evt_i.setup_tok && evt_i.ep_active) begin
      toggle_cmd_o.op  = usb_out_pkg::tog_clear;
      toggle_cmd_o.idx = idx_d;
    end else if (acked_d) begin
      toggle_cmd_o.op = usb_out_pkg::tog_flip;
    end
  end

  //////////////////////////////
  // State and outputs
  //////////////////////////////
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= usb_out_pkg::st_idle;
      timeout_q <= timeout_init;
    end else begin
      state_q   <= link_reset_i ? usb_out_pkg::st_idle : state_d;
      timeout_q <= timeout_d;
    end
  end

  // Reply and status pulses go out one cycle after the decision
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_pkt_start_o    <= 1'b0;
      tx_pid_o          <= pid_idle;
      out_ep_acked_o    <= 1'b0;
      out_ep_rollback_o <= 1'b0;
    end else begin
      tx_pkt_start_o    <= tx_start_d;
      tx_pid_o          <= tx_pid_d;
      out_ep_acked_o    <= acked_d;
      out_ep_rollback_o <= rollback_d;
    end
  end

  // Latch endpoint and transaction kind at the token
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_newpkt_o  <= 1'b0;
      out_ep_current_o <= '0;
      setup_q          <= 1'b0;
    end else begin
      out_ep_newpkt_o <= xact_start_o;
      if (xact_start_o) begin
        out_ep_current_o <= evt_i.ep_num;
        setup_q          <= evt_i.setup_tok;
      end
    end
  end

  // Setup flag per endpoint, OUT token clears it
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ep_setup_o <= '0;
    end else if (evt_i.ep_active) begin
      if (evt_i.setup_tok) begin
        out_ep_setup_o[idx_d] <= 1'b1;
      end else if (evt_i.out_tok) begin
        out_ep_setup_o[idx_d] <= 1'b0;
      end
    end
  end

  tx_pid_quiet: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !tx_pkt_start_o |-> (tx_pid_o == pid_idle));

  ack_rollback_excl: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    !(out_ep_acked_o && out_ep_rollback_o));

endmodule

//--- hdl/usb_out_data_path.sv
`timescale 1ns/1ps
`include "usb_out_defs.svh"

module usb_out_data_path (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  usb_out_pkg::rx_byte_t rx_byte_i,
  input  logic                  data_phase_i,
  input  logic                  xact_start_i,
  input  usb_out_pkg::ep_mask_t ep_full_i,
  input  usb_out_pkg::ep_idx_t  ep_idx_i,
  output usb_out_pkg::ep_put_t  ep_put_o,
  output logic                  nak_pending_o
);

  localparam usb_out_pkg::put_addr_t max_put_addr =
    usb_out_pkg::put_addr_t'(`USB_MAX_PKT_BYTES - 1);

  usb_out_pkg::put_addr_t addr_q;
  logic [7:0]             data_q;
  logic                   put_q;
  logic                   advance;

  assign ep_put_o.put  = put_q;
  assign ep_put_o.addr = addr_q;
  assign ep_put_o.data = data_q;

  // Hold offset once NAK is certain, or at the last slot
  assign advance = put_q && !nak_pending_o && (addr_q != max_put_addr);

  //////////////////////////////
  // Byte capture
  //////////////////////////////
  always_ff @(posedge clk_48mhz_i) begin
    if (rx_byte_i.put) begin
      data_q <= rx_byte_i.data;
    end
  end

  // Put strobe trails the rx strobe by one cycle
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_q <= 1'b0;
    end else begin
      put_q <= data_phase_i && rx_byte_i.put;
    end
  end

  //////////////////////////////
  // Offset and NAK tracking
  //////////////////////////////
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (xact_start_i) begin
      addr_q <= '0;
    end else if (data_phase_i && advance) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Any byte offered to a full endpoint forces a NAK
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_pending_o <= 1'b0;
    end else if (!data_phase_i) begin
      nak_pending_o <= 1'b0;
    end else if (put_q && ep_full_i[ep_idx_i]) begin
      nak_pending_o <= 1'b1;
    end
  end

  // Oversized packets pile up on the last slot
  put_addr_saturates: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (data_phase_i && (addr_q == max_put_addr)) |=> (addr_q != '0));

endmodule

//--- hdl/usb_data_toggle_reg.sv
`timescale 1ns/1ps
`include "usb_out_defs.svh"

module usb_data_toggle_reg (
  input  logic                     clk_48mhz_i,
  input  logic                     rst_ni,
  input  logic                     link_reset_i,
  input  usb_out_pkg::toggle_cmd_t cmd_i,
  output usb_out_pkg::ep_mask_t    toggle_o
);

  // One toggle bit per endpoint, DATA0 expected after clear
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_o <= '0;
    end else if (link_reset_i) begin
      // Bus reset restarts every pipe at DATA0
      toggle_o <= '0;
    end else begin
      unique case (cmd_i.op)
        usb_out_pkg::tog_clear: toggle_o[cmd_i.idx] <= 1'b0;
        usb_out_pkg::tog_flip:  toggle_o[cmd_i.idx] <= ~toggle_o[cmd_i.idx];
        default: ;
      endcase
    end
  end

  // Commands only target implemented endpoints
  toggle_idx_range: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
    (cmd_i.op != usb_out_pkg::tog_none) |-> (int'(cmd_i.idx) < `USB_NUM_OUT_EPS));

endmodule

//--- hdl/usb_out_pe.sv
`timescale 1ns/1ps

module usb_out_pe (
  input  logic                  clk_48mhz_i,
  input  logic                  rst_ni,
  input  logic                  link_reset_i,
  input  usb_out_pkg::dev_addr_t dev_addr_i,
  input  usb_out_pkg::rx_pkt_t  rx_pkt_i,
  input  usb_out_pkg::rx_byte_t rx_byte_i,
  input  usb_out_pkg::ep_cfg_t  ep_cfg_i,
  output logic                  tx_pkt_start_o,
  output usb_out_pkg::usb_pid_e tx_pid_o,
  output usb_out_pkg::ep_put_t  ep_put_o,
  output usb_out_pkg::endp_t    out_ep_current_o,
  output logic                  out_ep_newpkt_o,
  output logic                  out_ep_acked_o,
  output logic                  out_ep_rollback_o,
  output usb_out_pkg::ep_mask_t out_ep_setup_o,
  output usb_out_pkg::ep_mask_t out_data_toggle_o
);

  usb_out_pkg::tok_evt_t    evt;
  usb_out_pkg::toggle_cmd_t toggle_cmd;
  logic                     data_phase;
  logic                     xact_start;
  logic                     nak_pending;

  //////////////////////////////
  // Decode and sequencing
  //////////////////////////////
  usb_token_decode u_decode (
    .dev_addr_i (dev_addr_i),
    .rx_pkt_i   (rx_pkt_i),
    .ep_cfg_i   (ep_cfg_i),
    .toggle_i   (out_data_toggle_o),
    .evt_o      (evt)
  );

  usb_out_xact_fsm u_fsm (
    .clk_48mhz_i       (clk_48mhz_i),
    .rst_ni            (rst_ni),
    .link_reset_i      (link_reset_i),
    .evt_i             (evt),
    .rx_pkt_start_i    (rx_pkt_i.pkt_start),
    .ep_cfg_i          (ep_cfg_i),
    .nak_pending_i     (nak_pending),
    .tx_pkt_start_o    (tx_pkt_start_o),
    .tx_pid_o          (tx_pid_o),
    .out_ep_current_o  (out_ep_current_o),
    .out_ep_newpkt_o   (out_ep_newpkt_o),
    .out_ep_acked_o    (out_ep_acked_o),
    .out_ep_rollback_o (out_ep_rollback_o),
    .out_ep_setup_o    (out_ep_setup_o),
    .data_phase_o      (data_phase),
    .xact_start_o      (xact_start),
    .toggle_cmd_o      (toggle_cmd)
  );

  //////////////////////////////
  // Payload and toggles
  //////////////////////////////
  usb_out_data_path u_data_path (
    .clk_48mhz_i   (clk_48mhz_i),
    .rst_ni        (rst_ni),
    .rx_byte_i     (rx_byte_i),
    .data_phase_i  (data_phase),
    .xact_start_i  (xact_start),
    .ep_full_i     (ep_cfg_i.full),
    .ep_idx_i      (out_ep_current_o[$bits(usb_out_pkg::ep_idx_t)-1:0]),
    .ep_put_o      (ep_put_o),
    .nak_pending_o (nak_pending)
  );

  usb_data_toggle_reg u_toggle (
    .clk_48mhz_i  (clk_48mhz_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset_i),
    .cmd_i        (toggle_cmd),
    .toggle_o     (out_data_toggle_o)
  );

endmodule

//--- tests/tb_usb_out_pe.sv
`timescale 1ns/1ps
`include "usb_out_defs.svh"

module tb_usb_out_pe;

  localparam int num_cases       = 18;
  localparam int num_fields      = 13;
  localparam int watchdog_cycles = num_cases * 200;
  localparam usb_out_pkg::dev_addr_t own_addr = 7'h05;

  logic                   clk_48mhz;
  logic                   rst_n;
  logic                   link_reset;
  usb_out_pkg::dev_addr_t dev_addr;
  usb_out_pkg::rx_pkt_t   rx_pkt;
  usb_out_pkg::rx_byte_t  rx_byte;
  usb_out_pkg::ep_cfg_t   ep_cfg;
  logic                   tx_pkt_start;
  usb_out_pkg::usb_pid_e  tx_pid;
  usb_out_pkg::ep_put_t   ep_put;
  usb_out_pkg::endp_t     ep_current;
  logic                   ep_newpkt;
  logic                   ep_acked;
  logic                   ep_rollback;
  usb_out_pkg::ep_mask_t  ep_setup;
  usb_out_pkg::ep_mask_t  data_toggle;

  // Flat copy of the case file, num_fields words per case
  logic [7:0]  case_words [num_cases * num_fields];
  int unsigned errors;
  int unsigned checks;

  usb_out_pe UUT (
    .clk_48mhz_i       (clk_48mhz),
    .rst_ni            (rst_n),
    .link_reset_i      (link_reset),
    .dev_addr_i        (dev_addr),
    .rx_pkt_i          (rx_pkt),
    .rx_byte_i         (rx_byte),
    .ep_cfg_i          (ep_cfg),
    .tx_pkt_start_o    (tx_pkt_start),
    .tx_pid_o          (tx_pid),
    .ep_put_o          (ep_put),
    .out_ep_current_o  (ep_current),
    .out_ep_newpkt_o   (ep_newpkt),
    .out_ep_acked_o    (ep_acked),
    .out_ep_rollback_o (ep_rollback),
    .out_ep_setup_o    (ep_setup),
    .out_data_toggle_o (data_toggle)
  );

  // 8 ns period
  initial begin
    clk_48mhz = 1'b0;
    forever #4 clk_48mhz = ~clk_48mhz;
  end

  // Hang guard, 200 cycles per case
  initial begin
    repeat (watchdog_cycles) @(posedge clk_48mhz);
    $display("watchdog expired after %0d cycles, the cases did not complete", watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////
  task automatic check_value(input string name, input int unsigned got, input int unsigned exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Start strobe of a packet, fields untouched
  task automatic pulse_start();
    @(negedge clk_48mhz);
    rx_pkt.pkt_start = 1'b1;
    @(negedge clk_48mhz);
    rx_pkt.pkt_start = 1'b0;
  endtask

  // End strobe with PID and token fields, fields held afterwards
  task automatic pulse_end(input logic [3:0] pid, input logic [6:0] addr, input logic [3:0] endp);
    @(negedge clk_48mhz);
    rx_pkt.pkt_end   = 1'b1;
    rx_pkt.pkt_valid = 1'b1;
    rx_pkt.pid       = pid;
    rx_pkt.addr      = addr;
    rx_pkt.endp      = endp;
    @(negedge clk_48mhz);
    rx_pkt.pkt_end = 1'b0;
  endtask

  // Empty OUT with DATA0 on a DATA0 pipe, accepted data leaves the toggle at 1
  task automatic raise_toggle(input logic [6:0] addr, input logic [3:0] endp,
                              input logic [1:0] ep);
    pulse_start();
    pulse_end(4'h1, addr, endp);
    pulse_start();
    pulse_end(4'h3, addr, endp);
    repeat (4) @(negedge clk_48mhz);
    check_value("out_data_toggle_o[ep]", data_toggle[ep], 1);
  endtask

  // Random payload, each byte checked on the put stream
  task automatic send_bytes(input int nbytes, input logic exp_put, input logic ep_full);
    logic [7:0] byte_val;
    for (int i = 0; i < nbytes; i++) begin
      byte_val = 8'($urandom);
      @(negedge clk_48mhz);
      rx_byte.put  = 1'b1;
      rx_byte.data = byte_val;
      @(negedge clk_48mhz);
      rx_byte.put = 1'b0;
      check_value("ep_put_o.put", ep_put.put, exp_put);
      if (exp_put) begin
        // Full endpoint freezes the offset after the first byte
        check_value("ep_put_o.addr", ep_put.addr, (ep_full && i > 0) ? 1 : i);
        check_value("ep_put_o.data", ep_put.data, byte_val);
      end
    end
  endtask

  //////////////////////////////
  // One line of the case file
  //////////////////////////////
  task automatic run_case(input int idx);
    logic [7:0] f [num_fields];
    logic [1:0] ep;
    logic       in_hw;
    logic       tok_hit;
    logic       exp_xact;
    logic [3:0] got_pid;
    logic       got_acked;
    logic       got_rollback;
    int         tx_count;
    for (int i = 0; i < num_fields; i++) begin
      f[i] = case_words[idx * num_fields + i];
    end
    if (f[0] == 8'h2) begin
      // Bus reset between transactions
      @(negedge clk_48mhz);
      link_reset = 1'b1;
      @(negedge clk_48mhz);
      link_reset = 1'b0;
      check_value("out_data_toggle_o", data_toggle, 0);
    end else begin
      ep_cfg.enabled = f[5][3:0];
      ep_cfg.control = f[6][3:0];
      ep_cfg.full    = f[7][3:0];
      ep_cfg.stall   = f[8][3:0];
      // Unimplemented endpoints fold onto endpoint 0
      in_hw    = f[3] < `USB_NUM_OUT_EPS;
      ep       = in_hw ? f[3][1:0] : 2'd0;
      tok_hit  = (f[2][6:0] == own_addr) && in_hw && f[5][ep];
      exp_xact = tok_hit && ((f[1][3:0] == 4'h1) || ((f[1][3:0] == 4'hd) && f[6][ep]));
      // SETUP must pull a raised toggle back to DATA0
      if (tok_hit && (f[1][3:0] == 4'hd) && !f[7][ep] && !f[8][ep] && !data_toggle[ep]) begin
        raise_toggle(f[2][6:0], f[3][3:0], ep);
      end
      tx_count     = 0;
      got_pid      = 4'h0;
      got_acked    = 1'b0;
      got_rollback = 1'b0;
      pulse_start();
      pulse_end(f[1][3:0], f[2][6:0], f[3][3:0]);
      check_value("out_ep_newpkt_o", ep_newpkt, exp_xact);
      if (exp_xact) begin
        check_value("out_ep_current_o", ep_current, f[3]);
      end
      if (tok_hit && f[1][3:0] == 4'hd) begin
        check_value("out_data_toggle_o[ep]", data_toggle[ep], 0);
        check_value("out_ep_setup_o[ep]", ep_setup[ep], 1);
      end else if (tok_hit) begin
        check_value("out_ep_setup_o[ep]", ep_setup[ep], 0);
      end
      if (f[0] == 8'h1) begin
        // Host stays silent past the ack timeout
        repeat (`USB_ACK_TIMEOUT_CNT + 12) begin
          @(negedge clk_48mhz);
          tx_count += int'(tx_pkt_start);
        end
      end
      pulse_start();
      send_bytes($urandom_range(8, 1), exp_xact && (f[0] == 8'h0), f[7][ep]);
      pulse_end(f[4][3:0], f[2][6:0], f[3][3:0]);
      // Reply lands one or two cycles after the data end
      repeat (4) begin
        if (tx_pkt_start) begin
          tx_count++;
          got_pid = tx_pid;
        end
        got_acked    = got_acked | ep_acked;
        got_rollback = got_rollback | ep_rollback;
        @(negedge clk_48mhz);
      end
      check_value("tx_pkt_start_o pulses", tx_count, f[9] != 8'h0);
      check_value("tx_pid_o", got_pid, f[9]);
      check_value("out_ep_acked_o", got_acked, f[10]);
      check_value("out_ep_rollback_o", got_rollback, f[11]);
      check_value("out_data_toggle_o[ep]", data_toggle[ep], f[12]);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    errors = 0;
    checks = 0;
    void'($urandom(75741));
    rst_n      = 1'b0;
    link_reset = 1'b0;
    dev_addr   = own_addr;
    rx_pkt     = '0;
    rx_byte    = '0;
    ep_cfg     = '0;
    $readmemh("tests/usb_out_cases.txt", case_words);
    assert (!$isunknown(case_words[num_cases * num_fields - 1])) else begin
      errors++;
      $display("the case file tests/usb_out_cases.txt is missing or too short");
    end
    repeat (16) @(posedge clk_48mhz);
    @(negedge clk_48mhz);
    // Everything quiet while in reset
    check_value("tx_pkt_start_o", tx_pkt_start, 0);
    check_value("tx_pid_o", tx_pid, 0);
    check_value("out_ep_newpkt_o", ep_newpkt, 0);
    check_value("out_ep_acked_o", ep_acked, 0);
    check_value("out_ep_rollback_o", ep_rollback, 0);
    check_value("ep_put_o.put", ep_put.put, 0);
    check_value("out_ep_setup_o", ep_setup, 0);
    check_value("out_data_toggle_o", data_toggle, 0);
    rst_n = 1'b1;
    for (int n = 0; n < num_cases; n++) begin
      run_case(n);
      repeat (3) @(negedge clk_48mhz);
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tests/usb_out_cases.txt
// kind (0 token and data, 1 token then late data, 2 link reset) tpid addr endp dpid en ctl full stall
// expected: reply pid (0 none) acked rollback toggle; en ctl full stall are endpoint masks
0 1 05 1 3 f 1 0 0 2 1 0 1 // OUT ep1 DATA0 ACK
0 1 05 1 b f 1 0 0 2 1 0 0 // OUT ep1 DATA1 ACK
0 1 05 1 3 f 1 0 0 2 1 0 1 // OUT ep1 DATA0 ACK
0 1 05 1 3 f 1 0 0 2 0 1 1 // OUT ep1 repeated DATA0
0 d 05 0 3 f 1 0 0 2 1 0 1 // SETUP ep0 control
0 d 05 2 3 f 1 0 0 0 0 0 0 // SETUP ep2 not control
0 1 09 1 b f 1 0 0 0 0 0 1 // OUT other address
0 1 05 2 3 f 1 4 0 a 0 1 0 // OUT ep2 full
0 1 05 3 3 f 1 0 8 e 0 0 0 // OUT ep3 stalled
1 1 05 1 b f 1 0 0 0 0 0 1 // OUT ep1 data too late
0 1 05 1 b f 1 0 0 2 1 0 0 // OUT ep1 DATA1 ACK
2 0 00 0 0 0 0 0 0 0 0 0 0 // link reset
0 1 05 0 b f 1 0 0 2 0 1 0 // OUT ep0 DATA1 after reset
0 d 05 0 3 f 1 1 0 0 0 1 0 // SETUP ep0 full
0 1 05 5 3 f 1 0 0 0 0 0 0 // OUT ep5 not implemented
0 1 05 0 3 e 1 0 0 0 0 0 0 // OUT ep0 disabled
0 1 05 2 3 f 1 0 0 2 1 0 1 // OUT ep2 DATA0 ACK
0 d 05 0 3 f 1 0 0 2 1 0 1 // SETUP ep0 control

//--- build.f
+incdir+hdl
hdl/usb_out_pkg.sv
hdl/usb_token_decode.sv
hdl/usb_out_xact_fsm.sv
hdl/usb_out_data_path.sv
hdl/usb_data_toggle_reg.sv
hdl/usb_out_pe.sv
tests/tb_usb_out_pe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the USB OUT engine testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

log_file=sim.log
obj_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_usb_out_pe -f build.f \
  --Mdir "$obj_dir" -o sim_usb_out_pe
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$obj_dir/sim_usb_out_pe" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -qx "Simulation passed" "$log_file"; then
  exit 0
fi
echo "no pass message found in $log_file"
exit 1
